/* verilog.f */
rtl/win_pkg.sv
rtl/bus_pkg.sv
rtl/strip_if.sv
rtl/strip_ctrl.sv
rtl/word_counter.sv
rtl/mem_reader.sv
rtl/window_holder.sv
rtl/window_top.sv
tb/window_checker.sv
tb/tb_window_top.sv

/* run.sh */
#!/bin/sh
# build and run the window fetcher testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_window_top -f verilog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_window_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "all tests passed"; then
	exit 0
fi
echo "simulation did not report a pass"
exit 1

/* tb/tb_window_top.sv */
`timescale 1ns/100ps

module tb_window_top;

	localparam int NUM_CMDS = 8;		// entries in the command table.
	localparam int TIMEOUT_CYCLES = NUM_CMDS * 320 * 8 + 200;	// a fill per entry at worst word time.
	localparam logic [31:0] SEED = 32'ha8c6d51e;

	typedef struct packed {
		bus_pkg::cmd_op_t    op;
		bus_pkg::frame_row_t row;		// ignored by a scroll.
		win_pkg::offset_t    off_a;
		win_pkg::offset_t    off_b;
		win_pkg::offset_t    off_c;
	} cmd_entry_t;

	logic                clk;
	logic                rst_n;
	logic                cmd_req;
	bus_pkg::cmd_op_t    cmd_op;
	bus_pkg::frame_row_t cmd_row;
	logic                cmd_ack;
	logic                mem_req;
	bus_pkg::mem_addr_t  mem_addr;
	logic                mem_ack;
	win_pkg::word_t      mem_data;
	win_pkg::offset_t    window_offset;
	win_pkg::window_t    window_data;

	logic [7:0] pix_mult;		// odd pixel multiplier.
	logic [7:0] pix_add;		// pixel offset.
	int         tests_done;
	int         tests_bad;
	int         errors;
	int         cycles = 0;
	cmd_entry_t cmds [NUM_CMDS];

	window_top i_window_top (.*);

	window_checker i_window_checker (.*);

	// frame pixel at row r, byte column c.
	function automatic logic [7:0] frame_pixel(int r, int c);
		int v;
		v = (r * 80 + c) * int'(pix_mult) + int'(pix_add);
		return v[7:0];
	endfunction

	// word at a frame address, leftmost pixel in the top byte.
	function automatic win_pkg::word_t word_at(bus_pkg::mem_addr_t addr);
		win_pkg::word_t w;
		for (int p = 0; p < 4; p++)
			w[(3-p)*8 +: 8] = frame_pixel(int'(addr) / 20, (int'(addr) % 20) * 4 + p);
		return w;
	endfunction

	task automatic wait_ack(input logic level);
		while (cmd_ack !== level) begin
			@(posedge clk);
			#1;		// sample after the edge settles.
		end
	endtask

	task automatic set_offset(input win_pkg::offset_t off);
		window_offset = off;
		@(posedge clk);
		#1;
	endtask

	// one full host handshake with three window reads in the middle.
	task automatic run_command(input cmd_entry_t e);
		cmd_op  = e.op;
		cmd_row = e.row;
		cmd_req = 1'b1;
		wait_ack(1'b1);
		set_offset(e.off_a);
		set_offset(e.off_b);
		set_offset(e.off_c);
		cmd_req = 1'b0;
		wait_ack(1'b0);
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// memory model, random ack delay per word.
	initial begin
		logic [31:0] rnd;
		int          delay;
		rnd      = $urandom(SEED);		// seeds this process.
		pix_mult = rnd[7:0] | 8'h01;
		pix_add  = rnd[15:8];
		mem_ack  = 1'b0;
		mem_data = '0;
		forever begin
			@(posedge clk);
			#1;
			if (mem_req && !mem_ack) begin
				delay = $urandom_range(3, 0);
				repeat (delay) begin
					@(posedge clk);
					#1;
				end
				mem_data = word_at(mem_addr);
				mem_ack  = 1'b1;
				while (mem_req) begin		// hold ack until req falls.
					@(posedge clk);
					#1;
				end
				mem_ack = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run still busy after %0d cycles", cycles);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		rst_n         = 1'b0;
		cmd_req       = 1'b0;
		cmd_op        = bus_pkg::fill;
		cmd_row       = '0;
		window_offset = '0;
		cmds[0] = '{bus_pkg::fill,   6'd0,  7'd0, 7'd64, 7'd23};
		cmds[1] = '{bus_pkg::fill,   6'd5,  7'd0, 7'd64, 7'd37};
		cmds[2] = '{bus_pkg::fill,   6'd40, 7'd0, 7'd64, 7'd12};
		cmds[3] = '{bus_pkg::scroll, 6'd0,  7'd0, 7'd64, 7'd41};	// rows 41 to 56.
		cmds[4] = '{bus_pkg::scroll, 6'd9,  7'd7, 7'd64, 7'd30};
		cmds[5] = '{bus_pkg::scroll, 6'd0,  7'd0, 7'd64, 7'd55};	// rows 43 to 58.
		cmds[6] = '{bus_pkg::fill,   6'd20, 7'd0, 7'd64, 7'd9};	// full reload.
		cmds[7] = '{bus_pkg::scroll, 6'd0,  7'd0, 7'd64, 7'd33};
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (2) begin		// room for the reset check.
			@(posedge clk);
			#1;
		end
		for (int i = 0; i < NUM_CMDS; i++)
			run_command(cmds[i]);
		repeat (3) @(posedge clk);
		#1;
		$display("summary: %0d tests, %0d failing, %0d errors", tests_done, tests_bad, errors);
		if (tests_bad == 0 && errors == 0 && tests_done == NUM_CMDS + 1) begin
			$display("all tests passed");
		end else begin
			if (tests_done != NUM_CMDS + 1)
				$display("only %0d of %0d tests reported", tests_done, NUM_CMDS + 1);
			$display("tests failed");
		end
		$finish;
	end

endmodule : tb_window_top

/* tb/window_checker.sv */
`timescale 1ns/100ps

module window_checker (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cmd_req,
	input  bus_pkg::cmd_op_t    cmd_op,
	input  bus_pkg::frame_row_t cmd_row,
	input  logic                cmd_ack,
	input  logic                mem_req,
	input  bus_pkg::mem_addr_t  mem_addr,
	input  logic                mem_ack,
	input  win_pkg::offset_t    window_offset,
	input  win_pkg::window_t    window_data,
	input  logic [7:0]          pix_mult,
	input  logic [7:0]          pix_add,
	output int                  tests_done,
	output int                  tests_bad,
	output int                  errors
);

	logic [7:0]         exp_strip [16][80];	// expected strip with row 0 on top.
	int                 exp_base;			// frame row of strip row 0.
	int                 test_errs;
	int                 compares;
	int                 words_seen;			// memory reads started in this job.
	int                 want_addr;			// word address the current read must use.
	int                 want_words;			// reads a job of this kind makes.
	string              test_name;
	logic               reset_seen;
	logic               prev_req;
	logic               prev_ack;
	logic               prev_mreq;
	logic               prev_mack;
	bus_pkg::mem_addr_t prev_maddr;

	function automatic logic [7:0] frame_pixel(int r, int c);
		int v;
		v = ((r % 64) * 80 + c) * int'(pix_mult) + int'(pix_add);
		return v[7:0];
	endfunction

	// word address of the n-th read in a job.
	function automatic int expected_addr(input bus_pkg::cmd_op_t op, input int row, input int n);
		if (op == bus_pkg::fill)
			return ((row + n / 20) % 64) * 20 + n % 20;	// 16 rows from the given base.
		return ((exp_base + 16) % 64) * 20 + n;		// scroll reads the row below the strip.
	endfunction

	task automatic update_expected(input bus_pkg::cmd_op_t op, input bus_pkg::frame_row_t row);
		if (op == bus_pkg::fill) begin
			exp_base = int'(row);
			for (int k = 0; k < 16; k++)
				for (int c = 0; c < 80; c++)
					exp_strip[k][c] = frame_pixel(exp_base + k, c);
		end else begin
			for (int k = 0; k < 15; k++)
				for (int c = 0; c < 80; c++)
					exp_strip[k][c] = exp_strip[k+1][c];	// strip moves up.
			for (int c = 0; c < 80; c++)
				exp_strip[15][c] = frame_pixel(exp_base + 16, c);	// row just below the strip.
			exp_base = (exp_base + 1) % 64;
		end
	endtask

	task automatic flag_error(input string msg);
		$display("%0t: %s", $time, msg);
		test_errs++;
		errors++;
	endtask

	task automatic compare_window();
		logic [7:0] got;
		logic [7:0] want;
		logic       reported;
		reported = 1'b0;		// first bad pixel only.
		compares++;
		for (int k = 0; k < 16; k++) begin
			for (int m = 0; m < 16; m++) begin
				got  = window_data[(k*16+m)*8 +: 8];
				want = exp_strip[k][int'(window_offset) + m];
				if (got !== want && !reported) begin
					$display("** Error at %0t: window_data (%0d,%0d) offset %0d expected %h got %h",
						$time, k, m, window_offset, want, got);
					reported = 1'b1;
					test_errs++;
					errors++;
				end
			end
		end
	endtask

	task automatic finish_test();
		if (compares == 0)
			flag_error("no window was compared in this test");
		$display("test %0d (%s, base %0d): %0d compares, %0d errors, %s", tests_done, test_name,
			exp_base, compares, test_errs, (test_errs == 0) ? "ok" : "FAIL");
		tests_done++;
		if (test_errs != 0)
			tests_bad++;
		test_errs = 0;
		compares  = 0;
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 0; k < 16; k++)
				for (int c = 0; c < 80; c++)
					exp_strip[k][c] = 8'h00;	// strip clears on reset.
			{exp_base, test_errs, compares, tests_done, tests_bad, errors} = '0;
			{reset_seen, prev_req, prev_ack, prev_mreq, prev_mack} = '0;
			prev_maddr = '0;
			words_seen = 0;
		end else begin
			if (!reset_seen) begin
				reset_seen = 1'b1;
				test_name  = "reset";
				if (cmd_ack !== 1'b0)
					$display("** Error at %0t: cmd_ack expected 0 got %b", $time, cmd_ack);
				if (mem_req !== 1'b0)
					$display("** Error at %0t: mem_req expected 0 got %b", $time, mem_req);
				test_errs += int'(cmd_ack !== 1'b0) + int'(mem_req !== 1'b0);
				errors    += int'(cmd_ack !== 1'b0) + int'(mem_req !== 1'b0);
				compare_window();
				finish_test();
			end
			if (!prev_req && cmd_req)
				words_seen = 0;		// host opens a new job.
			if (!prev_mreq && mem_req) begin
				want_addr = expected_addr(cmd_op, int'(cmd_row), words_seen);
				if (int'(mem_addr) != want_addr) begin
					$display("** Error at %0t: mem_addr expected %0d got %0d",
						$time, want_addr, mem_addr);
					test_errs++;
					errors++;
				end
				words_seen++;
			end
			if (prev_mreq && mem_req && mem_addr !== prev_maddr)
				flag_error("mem_addr changed while mem_req was high");
			if (prev_mreq && !mem_req && !prev_mack)
				flag_error("mem_req dropped before mem_ack arrived");
			if (!prev_ack && cmd_ack) begin
				if (!prev_req)
					flag_error("cmd_ack rose with no pending cmd_req");
				want_words = (cmd_op == bus_pkg::fill) ? 320 : 20;	// whole strip or one row.
				if (words_seen != want_words)
					flag_error($sformatf("job made %0d memory reads instead of %0d",
						words_seen, want_words));
				test_name = (cmd_op == bus_pkg::scroll) ? "scroll" : "fill";
				update_expected(cmd_op, cmd_row);
			end
			if (prev_ack && !cmd_ack) begin
				if (prev_req)
					flag_error("cmd_ack dropped while cmd_req was still high");
				finish_test();
			end
			if (cmd_ack)
				compare_window();		// strip is stable while acked.
			prev_req   = cmd_req;
			prev_ack   = cmd_ack;
			prev_mreq  = mem_req;
			prev_mack  = mem_ack;
			prev_maddr = mem_addr;
		end
	end

endmodule : window_checker

/* rtl/window_top.sv */
`timescale 1ns/100ps

module window_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cmd_req,		// host command handshake.
	input  bus_pkg::cmd_op_t    cmd_op,
	input  bus_pkg::frame_row_t cmd_row,
	output logic                cmd_ack,
	output logic                mem_req,		// memory read handshake.
	output bus_pkg::mem_addr_t  mem_addr,
	input  logic                mem_ack,
	input  win_pkg::word_t      mem_data,
	input  win_pkg::offset_t    window_offset,	// window column select.
	output win_pkg::window_t    window_data		// valid while idle.
);

	logic                start;
	logic                scroll_mode;
	bus_pkg::frame_row_t base_row;
	logic                rd_go;
	logic                word_done;
	win_pkg::row_idx_t   row;
	win_pkg::col_idx_t   col;
	bus_pkg::mem_addr_t  cnt_addr;		// address from the counter.
	logic                first;
	logic                last;

	strip_if sif ();		// reader to strip link.

	strip_ctrl i_strip_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.cmd_req     (cmd_req),
		.cmd_op      (cmd_op),
		.cmd_row     (cmd_row),
		.cmd_ack     (cmd_ack),
		.start       (start),
		.scroll_mode (scroll_mode),
		.base_row    (base_row),
		.rd_go       (rd_go),
		.word_done   (word_done),
		.last        (last)
	);

	word_counter i_word_counter (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.scroll_mode (scroll_mode),
		.base_row    (base_row),
		.step        (word_done),		// one step per finished word.
		.row         (row),
		.col         (col),
		.mem_addr    (cnt_addr),
		.first       (first),
		.last        (last)
	);

	mem_reader i_mem_reader (
		.clk      (clk),
		.rst_n    (rst_n),
		.go       (rd_go),
		.addr     (cnt_addr),
		.row      (row),
		.col      (col),
		.shift    (first),		// first scroll word shifts the strip.
		.mem_req  (mem_req),
		.mem_addr (mem_addr),
		.mem_ack  (mem_ack),
		.mem_data (mem_data),
		.done     (word_done),
		.sif      (sif.src)
	);

	window_holder i_window_holder (
		.clk           (clk),
		.rst_n         (rst_n),
		.sif           (sif.dst),
		.window_offset (window_offset),
		.window_data   (window_data)
	);

endmodule : window_top

/* rtl/window_holder.sv */
`timescale 1ns/100ps

module window_holder (
	input  logic             clk,
	input  logic             rst_n,
	strip_if.dst             sif,
	input  win_pkg::offset_t window_offset,		// left column of the window.
	output win_pkg::window_t window_data		// flat 16x16 pixels.
);

	win_pkg::pixel_t [win_pkg::STRIP_ROWS-1:0][win_pkg::STRIP_BYTES-1:0] strip;	// row 0 is the top row.
	win_pkg::pixel_t [win_pkg::WORD_PIXELS-1:0] word_px;		// word split into pixels, index 0 leftmost.

	always_comb begin
		for (int p = 0; p < win_pkg::WORD_PIXELS; p++) begin
			word_px[p] = sif.data[(win_pkg::WORD_PIXELS-1-p)*8 +: 8];	// top byte first.
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			strip <= '0;		// blank strip.
		end else if (sif.load) begin
			if (sif.new_row) begin
				for (int i = 0; i < win_pkg::STRIP_ROWS - 1; i++) begin
					strip[i] <= strip[i+1];		// move up one row.
				end
				strip[win_pkg::STRIP_ROWS-1] <= '0;		// clear the bottom row.
				for (int p = 0; p < win_pkg::WORD_PIXELS; p++) begin
					strip[win_pkg::STRIP_ROWS-1][p] <= word_px[p];	// then place at col 0.
				end
			end else begin
				for (int p = 0; p < win_pkg::WORD_PIXELS; p++) begin
					strip[sif.row][sif.col*win_pkg::WORD_PIXELS+p] <= word_px[p];
				end
			end
		end
	end

	// window tap, pure mux on the offset.
	always_comb begin
		for (int k = 0; k < win_pkg::WIN_SIZE; k++) begin
			for (int m = 0; m < win_pkg::WIN_SIZE; m++) begin
				window_data[(k*win_pkg::WIN_SIZE+m)*8 +: 8] = strip[k][window_offset+m];
			end
		end
	end

	// host never points past the right edge.
	a_offset_range: assert property (@(posedge clk) disable iff (!rst_n)
		window_offset <= win_pkg::offset_t'(win_pkg::MAX_OFFSET))
		else $error("window_offset beyond strip edge");

endmodule : window_holder

/* rtl/mem_reader.sv */
`timescale 1ns/100ps

module mem_reader (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               go,			// start one word read.
	input  bus_pkg::mem_addr_t addr,		// word address to read.
	input  win_pkg::row_idx_t  row,			// placement row.
	input  win_pkg::col_idx_t  col,			// placement column.
	input  logic               shift,		// shift the strip with this word.
	output logic               mem_req,		// four-phase request.
	output bus_pkg::mem_addr_t mem_addr,	// stable while mem_req is high.
	input  logic               mem_ack,		// memory acknowledge.
	input  win_pkg::word_t     mem_data,	// valid with mem_ack.
	output logic               done,		// word written to the strip.
	strip_if.src               sif
);

	win_pkg::word_t    data_q;		// captured word.
	win_pkg::row_idx_t row_q;
	win_pkg::col_idx_t col_q;
	logic              shift_q;		// word opens a new row.
	logic              drop_wait;	// req dropped, waiting for ack to fall.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_req   <= 1'b0;
			mem_addr  <= '0;
			shift_q   <= 1'b0;
			drop_wait <= 1'b0;
			done      <= 1'b0;
		end else begin
			done <= 1'b0;
			if (go) begin
				mem_addr <= addr;		// held for the whole read.
				shift_q  <= shift;
				mem_req  <= 1'b1;
			end else if (mem_req && mem_ack) begin
				mem_req   <= 1'b0;		// phase 3, data taken.
				drop_wait <= 1'b1;
			end else if (drop_wait && !mem_ack) begin
				drop_wait <= 1'b0;		// phase 4 seen.
				done      <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (go) begin
			row_q <= row;
			col_q <= col;
		end
		if (mem_req && mem_ack)
			data_q <= mem_data;		// sampled on ack.
	end

	assign sif.data    = data_q;
	assign sif.row     = row_q;
	assign sif.col     = col_q;
	assign sif.load    = done;				// strip write with word_done.
	assign sif.new_row = done && shift_q;

	// controller waits for done before the next go.
	a_go_idle: assert property (@(posedge clk) disable iff (!rst_n)
		go |-> !mem_req && !drop_wait && !done)
		else $error("read started while previous read busy");

endmodule : mem_reader

/* rtl/word_counter.sv */
`timescale 1ns/100ps

module word_counter (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,			// restart at word 0.
	input  logic                scroll_mode,	// only the bottom row is fetched.
	input  bus_pkg::frame_row_t base_row,		// frame row of strip row 0, or the scroll row.
	input  logic                step,			// advance one word.
	output win_pkg::row_idx_t   row,			// strip row for placement.
	output win_pkg::col_idx_t   col,			// word column.
	output bus_pkg::mem_addr_t  mem_addr,		// word address in the frame.
	output logic                first,			// first word of a scroll.
	output logic                last			// final word of the job.
);

	win_pkg::row_idx_t   row_cnt;			// rows fetched so far in a fill.
	bus_pkg::frame_row_t frame_row;			// frame row of the current word.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row_cnt <= '0;
			col     <= '0;
		end else if (start) begin
			row_cnt <= '0;
			col     <= '0;
		end else if (step) begin
			if (col == win_pkg::col_idx_t'(win_pkg::WORDS_PER_ROW - 1)) begin
				col     <= '0;		// wrap to the next row.
				row_cnt <= row_cnt + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	assign row = scroll_mode ? win_pkg::row_idx_t'(win_pkg::STRIP_ROWS - 1) : row_cnt;	// scroll lands in row 15.
	assign frame_row = scroll_mode ? base_row : base_row + bus_pkg::frame_row_t'(row_cnt);
	assign mem_addr = bus_pkg::mem_addr_t'(frame_row) * bus_pkg::mem_addr_t'(win_pkg::WORDS_PER_ROW)
		+ bus_pkg::mem_addr_t'(col);	// row * 20 + col.

	assign first = scroll_mode && (col == '0);		// this word triggers the shift.
	assign last = (col == win_pkg::col_idx_t'(win_pkg::WORDS_PER_ROW - 1)) &&
		(scroll_mode || (row_cnt == win_pkg::row_idx_t'(win_pkg::STRIP_ROWS - 1)));

endmodule : word_counter

/* rtl/strip_ctrl.sv */
`timescale 1ns/100ps

module strip_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cmd_req,		// host request, four-phase.
	input  bus_pkg::cmd_op_t    cmd_op,			// fill or scroll.
	input  bus_pkg::frame_row_t cmd_row,		// base row for a fill.
	output logic                cmd_ack,		// job finished.
	output logic                start,			// one-cycle counter restart.
	output logic                scroll_mode,	// job is a scroll.
	output bus_pkg::frame_row_t base_row,		// first frame row of the job.
	output logic                rd_go,			// fetch word at counter address.
	input  logic                word_done,		// reader finished a word.
	input  logic                last			// that word closes the job.
);

	bus_pkg::ctrl_state_t state;			// job state.
	bus_pkg::frame_row_t  next_row;			// frame row the next scroll fetches.

	assign cmd_ack = (state == bus_pkg::ack_hi) || (state == bus_pkg::ack_wait);	// held until req drops.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= bus_pkg::idle;
			start       <= 1'b0;
			rd_go       <= 1'b0;
			scroll_mode <= 1'b0;
			base_row    <= '0;
			next_row    <= bus_pkg::frame_row_t'(win_pkg::STRIP_ROWS);	// scroll before fill reads row 16.
		end else begin
			start <= 1'b0;		// pulses by default.
			rd_go <= 1'b0;
			case (state)
				bus_pkg::idle: begin
					if (cmd_req) begin
						scroll_mode <= (cmd_op == bus_pkg::scroll);
						base_row    <= (cmd_op == bus_pkg::scroll) ? next_row : cmd_row;	// scroll ignores cmd_row.
						start       <= 1'b1;
						state       <= bus_pkg::run;
					end
				end
				bus_pkg::run: begin
					if (start) begin
						rd_go <= 1'b1;		// counter is at word 0 now.
					end else if (word_done) begin
						if (last)
							state <= bus_pkg::ack_hi;	// ack one cycle after last word.
						else
							rd_go <= 1'b1;	// counter steps on the same edge.
					end
				end
				bus_pkg::ack_hi: begin
					// strip now starts one row lower after a scroll, at base after a fill.
					if (scroll_mode)
						next_row <= base_row + 1'b1;
					else
						next_row <= base_row + bus_pkg::frame_row_t'(win_pkg::STRIP_ROWS);
					state <= bus_pkg::ack_wait;
				end
				bus_pkg::ack_wait: begin
					if (!cmd_req)
						state <= bus_pkg::idle;	// ack falls with it.
				end
				default: state <= bus_pkg::idle;
			endcase
		end
	end

	// host keeps the request up for the whole job.
	a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		(state == bus_pkg::run) && !cmd_ack |-> cmd_req)
		else $error("cmd_req dropped before cmd_ack");

endmodule : strip_ctrl

/* rtl/strip_if.sv */
`timescale 1ns/100ps

interface strip_if;

	win_pkg::word_t    data;		// captured memory word.
	win_pkg::row_idx_t row;			// strip row to write.
	win_pkg::col_idx_t col;			// word column to write.
	logic              load;		// one-cycle write strobe.
	logic              new_row;		// shift up before placing at row 15, col 0.

	modport src (
		output data, row, col, load, new_row
	);

	modport dst (
		input data, row, col, load, new_row
	);

endinterface : strip_if

/* rtl/bus_pkg.sv */
package bus_pkg;

	localparam int FRAME_ROWS = 64;		// rows in the external frame.
	localparam int FRAME_WORDS = FRAME_ROWS * win_pkg::WORDS_PER_ROW;	// 1280 words.

	// frame row number.
	typedef logic [$clog2(FRAME_ROWS)-1:0] frame_row_t;

	// word address, frame row * 20 + word column.
	typedef logic [$clog2(FRAME_WORDS)-1:0] mem_addr_t;

	// host command opcode.
	typedef enum logic {
		fill,		// load the whole 16-row strip.
		scroll		// shift down one row, load the new bottom row.
	} cmd_op_t;

	// job controller states.
	typedef enum logic [1:0] {
		idle,		// waiting for cmd_req.
		run,		// words being fetched.
		ack_hi,		// first cycle of cmd_ack, scroll row updated here.
		ack_wait	// cmd_ack held until cmd_req drops.
	} ctrl_state_t;

endpackage : bus_pkg

/* rtl/win_pkg.sv */
package win_pkg;

	localparam int WIN_SIZE      = 16;		// window edge in pixels.
	localparam int STRIP_ROWS    = 16;		// rows held in the strip.
	localparam int STRIP_BYTES   = 80;		// strip width, one byte per pixel.
	localparam int WORD_PIXELS   = 4;		// pixels packed in one memory word.
	localparam int WORDS_PER_ROW = STRIP_BYTES / WORD_PIXELS;	// 20 words per frame row.
	localparam int MAX_OFFSET    = STRIP_BYTES - WIN_SIZE;	// rightmost window start, 64.

	// one 8-bit pixel.
	typedef logic [7:0] pixel_t;

	// memory word, leftmost pixel in the top byte.
	typedef logic [WORD_PIXELS*8-1:0] word_t;

	// strip row index, 0 to 15.
	typedef logic [$clog2(STRIP_ROWS)-1:0] row_idx_t;

	// word column inside a row, 0 to 19.
	typedef logic [$clog2(WORDS_PER_ROW)-1:0] col_idx_t;

	// window column offset, 0 to 64.
	typedef logic [$clog2(MAX_OFFSET+1)-1:0] offset_t;

	// flat 16x16 window, pixel (k, m) sits at bits (k*16+m)*8.
	typedef logic [WIN_SIZE*WIN_SIZE*8-1:0] window_t;

endpackage : win_pkg
